//--- Makefile
TOP = tb_result_bus

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module result_bus_top \
		hw/result_bus_pkg.sv hw/slot_reservation.sv hw/result_pipe.sv \
		hw/gpr_bus_arbiter.sv hw/fpr_bus_arbiter.sv hw/result_bus_top.sv

sim:
	verilator --binary --timing --timescale 1ns/1ps -f result_bus.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- hw/fpr_bus_arbiter.sv
`default_nettype none

module fpr_bus_arbiter (
	input logic clk,
	input logic reset,
	input logic fdiv_fsqrt_req,
	input result_bus_pkg::tag_t fdiv_fsqrt_tag,
	input result_bus_pkg::data_t fdiv_fsqrt_data,
	output logic fdiv_fsqrt_ready,
	input logic fadd_fsub_req,
	input result_bus_pkg::tag_t fadd_fsub_tag,
	input result_bus_pkg::data_t fadd_fsub_data,
	output logic fadd_fsub_ready,
	input logic fmul_req,
	input result_bus_pkg::tag_t fmul_tag,
	input result_bus_pkg::data_t fmul_data,
	output logic fmul_ready,
	input logic itof_req,
	input result_bus_pkg::tag_t itof_tag,
	input result_bus_pkg::data_t itof_data,
	output logic itof_ready,
	input logic fpr_lw_req,
	input result_bus_pkg::tag_t fpr_lw_tag,
	input result_bus_pkg::data_t fpr_lw_data,
	output logic fpr_lw_ready,
	input logic fmov_req,
	input result_bus_pkg::tag_t fmov_tag,
	input result_bus_pkg::data_t fmov_data,
	output logic fmov_ready,
	input logic fpr_in_req,
	input result_bus_pkg::tag_t fpr_in_tag,
	input result_bus_pkg::data_t fpr_in_data,
	output logic fpr_in_ready,
	output logic fpr_cdb_valid,
	output result_bus_pkg::tag_t fpr_cdb_tag,
	output result_bus_pkg::data_t fpr_cdb_data
);
	import result_bus_pkg::*;

	logic [FPR_SLOTS-1:0] occupied;
	logic [FPR_SLOTS-1:0] insert;
	logic [2:0] insert_unit [FPR_SLOTS];
	logic [2:0] head_unit;

	logic fdiv_fsqrt_acc;
	logic fadd_fsub_acc;
	logic fmul_acc;
	logic itof_acc;
	logic fpr_lw_acc;
	logic fmov_acc;

	tag_t fdiv_fsqrt_res_tag;
	tag_t fadd_fsub_res_tag;
	tag_t fmul_res_tag;
	tag_t itof_res_tag;
	tag_t fpr_lw_res_tag;
	tag_t fmov_res_tag;
	data_t fdiv_fsqrt_res_data;
	data_t fadd_fsub_res_data;
	data_t fmul_res_data;
	data_t itof_res_data;
	data_t fpr_lw_res_data;
	data_t fmov_res_data;

	////////////////////
	// ready rules
	////////////////////

	// a source looks one slot above where it inserts
	assign fdiv_fsqrt_ready = 1'b1;
	assign fadd_fsub_ready = !occupied[LAT_FADD_FSUB];
	assign fmul_ready = !occupied[LAT_FMUL];
	assign itof_ready = !occupied[LAT_ITOF];
	assign fpr_lw_ready = !occupied[LAT_FPR_LW];
	assign fmov_ready = !occupied[LAT_FMOV] && !fpr_lw_req;
	assign fpr_in_ready = !occupied[0];

	assign fdiv_fsqrt_acc = fdiv_fsqrt_req && fdiv_fsqrt_ready;
	assign fadd_fsub_acc = fadd_fsub_req && fadd_fsub_ready;
	assign fmul_acc = fmul_req && fmul_ready;
	assign itof_acc = itof_req && itof_ready;
	assign fpr_lw_acc = fpr_lw_req && fpr_lw_ready;
	assign fmov_acc = fmov_req && fmov_ready;

	////////////////////
	// reservations
	////////////////////

	always_comb begin
		insert = '0;
		insert[LAT_FDIV_FSQRT-1] = fdiv_fsqrt_acc;
		insert[LAT_FADD_FSUB-1] = fadd_fsub_acc;
		insert[LAT_FMUL-1] = fmul_acc;
		insert[LAT_ITOF-1] = itof_acc;
		insert[LAT_FPR_LW-1] = fpr_lw_acc || fmov_acc;
	end

	// slots without an insert point keep a harmless id
	always_comb begin
		for (int i = 0; i < FPR_SLOTS; i++) begin
			insert_unit[i] = 3'(FPR_FDIV_FSQRT);
		end
		insert_unit[LAT_FADD_FSUB-1] = 3'(FPR_FADD_FSUB);
		insert_unit[LAT_FMUL-1] = 3'(FPR_FMUL);
		insert_unit[LAT_ITOF-1] = 3'(FPR_ITOF);
		insert_unit[LAT_FPR_LW-1] = fpr_lw_acc ? 3'(FPR_LW) : 3'(FPR_FMOV);
	end

	slot_reservation #(.DEPTH(FPR_SLOTS)) slots_i (
		.clk,
		.reset,
		.insert,
		.insert_unit,
		.occupied,
		.head_unit
	);

	// fdiv and fsqrt share one source
	result_pipe #(.STAGES(LAT_FDIV_FSQRT)) fdiv_fsqrt_pipe_i (
		.clk,
		.in_tag(fdiv_fsqrt_tag),
		.in_data(fdiv_fsqrt_data),
		.out_tag(fdiv_fsqrt_res_tag),
		.out_data(fdiv_fsqrt_res_data)
	);

	result_pipe #(.STAGES(LAT_FADD_FSUB)) fadd_fsub_pipe_i (
		.clk,
		.in_tag(fadd_fsub_tag),
		.in_data(fadd_fsub_data),
		.out_tag(fadd_fsub_res_tag),
		.out_data(fadd_fsub_res_data)
	);

	result_pipe #(.STAGES(LAT_FMUL)) fmul_pipe_i (
		.clk,
		.in_tag(fmul_tag),
		.in_data(fmul_data),
		.out_tag(fmul_res_tag),
		.out_data(fmul_res_data)
	);

	result_pipe #(.STAGES(LAT_ITOF)) itof_pipe_i (
		.clk,
		.in_tag(itof_tag),
		.in_data(itof_data),
		.out_tag(itof_res_tag),
		.out_data(itof_res_data)
	);

	result_pipe #(.STAGES(LAT_FPR_LW)) fpr_lw_pipe_i (
		.clk,
		.in_tag(fpr_lw_tag),
		.in_data(fpr_lw_data),
		.out_tag(fpr_lw_res_tag),
		.out_data(fpr_lw_res_data)
	);

	result_pipe #(.STAGES(LAT_FMOV)) fmov_pipe_i (
		.clk,
		.in_tag(fmov_tag),
		.in_data(fmov_data),
		.out_tag(fmov_res_tag),
		.out_data(fmov_res_data)
	);

	////////////////////
	// bus select
	////////////////////

	assign fpr_cdb_valid = occupied[0] || (fpr_in_req && fpr_in_ready);

	always_comb begin
		fpr_cdb_tag = fpr_in_tag;
		fpr_cdb_data = fpr_in_data;
		if (occupied[0]) begin
			case (head_unit)
				3'(FPR_FDIV_FSQRT): begin
					fpr_cdb_tag = fdiv_fsqrt_res_tag;
					fpr_cdb_data = fdiv_fsqrt_res_data;
				end
				3'(FPR_FADD_FSUB): begin
					fpr_cdb_tag = fadd_fsub_res_tag;
					fpr_cdb_data = fadd_fsub_res_data;
				end
				3'(FPR_FMUL): begin
					fpr_cdb_tag = fmul_res_tag;
					fpr_cdb_data = fmul_res_data;
				end
				3'(FPR_ITOF): begin
					fpr_cdb_tag = itof_res_tag;
					fpr_cdb_data = itof_res_data;
				end
				3'(FPR_LW): begin
					fpr_cdb_tag = fpr_lw_res_tag;
					fpr_cdb_data = fpr_lw_res_data;
				end
				default: begin
					fpr_cdb_tag = fmov_res_tag;
					fpr_cdb_data = fmov_res_data;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/gpr_bus_arbiter.sv
`default_nettype none

module gpr_bus_arbiter (
	input logic clk,
	input logic reset,
	input logic ftoi_req,
	input result_bus_pkg::tag_t ftoi_tag,
	input result_bus_pkg::data_t ftoi_data,
	output logic ftoi_ready,
	input logic gpr_lw_req,
	input result_bus_pkg::tag_t gpr_lw_tag,
	input result_bus_pkg::data_t gpr_lw_data,
	output logic gpr_lw_ready,
	input logic add_sub_req,
	input result_bus_pkg::tag_t add_sub_tag,
	input result_bus_pkg::data_t add_sub_data,
	output logic add_sub_ready,
	input logic mov_req,
	input result_bus_pkg::tag_t mov_tag,
	input result_bus_pkg::data_t mov_data,
	output logic mov_ready,
	input logic gpr_in_req,
	input result_bus_pkg::tag_t gpr_in_tag,
	input result_bus_pkg::data_t gpr_in_data,
	output logic gpr_in_ready,
	output logic gpr_cdb_valid,
	output result_bus_pkg::tag_t gpr_cdb_tag,
	output result_bus_pkg::data_t gpr_cdb_data
);
	import result_bus_pkg::*;

	logic [GPR_SLOTS-1:0] occupied;
	logic [GPR_SLOTS-1:0] insert;
	logic [2:0] insert_unit [GPR_SLOTS];
	logic [2:0] head_unit;

	logic ftoi_acc;
	logic gpr_lw_acc;
	logic add_sub_acc;
	logic mov_acc;

	tag_t ftoi_res_tag;
	tag_t gpr_lw_res_tag;
	tag_t add_sub_res_tag;
	tag_t mov_res_tag;
	data_t ftoi_res_data;
	data_t gpr_lw_res_data;
	data_t add_sub_res_data;
	data_t mov_res_data;

	////////////////////
	// ready rules
	////////////////////

	assign ftoi_ready = 1'b1;
	assign gpr_lw_ready = !occupied[LAT_GPR_LW];
	assign add_sub_ready = !occupied[LAT_ADD_SUB] && !gpr_lw_req;
	assign mov_ready = !occupied[LAT_MOV] && !gpr_lw_req && !add_sub_req;
	assign gpr_in_ready = !occupied[0];

	assign ftoi_acc = ftoi_req && ftoi_ready;
	assign gpr_lw_acc = gpr_lw_req && gpr_lw_ready;
	assign add_sub_acc = add_sub_req && add_sub_ready;
	assign mov_acc = mov_req && mov_ready;

	////////////////////
	// reservations
	////////////////////

	// lw, add_sub and mov share the one-cycle slot
	always_comb begin
		insert = '0;
		insert[LAT_FTOI-1] = ftoi_acc;
		insert[LAT_GPR_LW-1] = gpr_lw_acc || add_sub_acc || mov_acc;
	end

	always_comb begin
		for (int i = 0; i < GPR_SLOTS; i++) begin
			insert_unit[i] = 3'(GPR_FTOI);
		end
		if (gpr_lw_acc) begin
			insert_unit[LAT_GPR_LW-1] = 3'(GPR_LW);
		end else if (add_sub_acc) begin
			insert_unit[LAT_ADD_SUB-1] = 3'(GPR_ADD_SUB);
		end else begin
			insert_unit[LAT_MOV-1] = 3'(GPR_MOV);
		end
	end

	slot_reservation #(.DEPTH(GPR_SLOTS)) slots_i (
		.clk,
		.reset,
		.insert,
		.insert_unit,
		.occupied,
		.head_unit
	);

	result_pipe #(.STAGES(LAT_FTOI)) ftoi_pipe_i (
		.clk,
		.in_tag(ftoi_tag),
		.in_data(ftoi_data),
		.out_tag(ftoi_res_tag),
		.out_data(ftoi_res_data)
	);

	result_pipe #(.STAGES(LAT_GPR_LW)) gpr_lw_pipe_i (
		.clk,
		.in_tag(gpr_lw_tag),
		.in_data(gpr_lw_data),
		.out_tag(gpr_lw_res_tag),
		.out_data(gpr_lw_res_data)
	);

	result_pipe #(.STAGES(LAT_ADD_SUB)) add_sub_pipe_i (
		.clk,
		.in_tag(add_sub_tag),
		.in_data(add_sub_data),
		.out_tag(add_sub_res_tag),
		.out_data(add_sub_res_data)
	);

	result_pipe #(.STAGES(LAT_MOV)) mov_pipe_i (
		.clk,
		.in_tag(mov_tag),
		.in_data(mov_data),
		.out_tag(mov_res_tag),
		.out_data(mov_res_data)
	);

	////////////////////
	// bus select
	////////////////////

	assign gpr_cdb_valid = occupied[0] || (gpr_in_req && gpr_in_ready);

	// empty head slot lets gpr_in through in the same cycle
	always_comb begin
		gpr_cdb_tag = gpr_in_tag;
		gpr_cdb_data = gpr_in_data;
		if (occupied[0]) begin
			case (head_unit)
				3'(GPR_FTOI): begin
					gpr_cdb_tag = ftoi_res_tag;
					gpr_cdb_data = ftoi_res_data;
				end
				3'(GPR_LW): begin
					gpr_cdb_tag = gpr_lw_res_tag;
					gpr_cdb_data = gpr_lw_res_data;
				end
				3'(GPR_ADD_SUB): begin
					gpr_cdb_tag = add_sub_res_tag;
					gpr_cdb_data = add_sub_res_data;
				end
				default: begin
					gpr_cdb_tag = mov_res_tag;
					gpr_cdb_data = mov_res_data;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/result_bus_pkg.sv
`default_nettype none

package result_bus_pkg;

	////////////////////
	// widths
	////////////////////

	localparam int TAG_WIDTH = 4;
	localparam int DATA_WIDTH = 32;

	typedef logic [TAG_WIDTH-1:0] tag_t;
	typedef logic [DATA_WIDTH-1:0] data_t;

	////////////////////
	// unit latencies
	////////////////////

	// cycles from acceptance to the bus
	localparam int LAT_FTOI = 3;
	localparam int LAT_GPR_LW = 1;
	localparam int LAT_ADD_SUB = 1;
	localparam int LAT_MOV = 1;
	localparam int LAT_FDIV_FSQRT = 14;
	localparam int LAT_FADD_FSUB = 6;
	localparam int LAT_FMUL = 4;
	localparam int LAT_ITOF = 3;
	localparam int LAT_FPR_LW = 1;
	localparam int LAT_FMOV = 1;

	// ring depth = longest latency on that bus
	localparam int GPR_SLOTS = 3;
	localparam int FPR_SLOTS = 14;

	typedef enum logic [1:0] {
		GPR_FTOI,
		GPR_LW,
		GPR_ADD_SUB,
		GPR_MOV
	} gpr_unit_t;

	typedef enum logic [2:0] {
		FPR_FDIV_FSQRT,
		FPR_FADD_FSUB,
		FPR_FMUL,
		FPR_ITOF,
		FPR_LW,
		FPR_FMOV
	} fpr_unit_t;

endpackage

`default_nettype wire

//--- hw/result_bus_top.sv
`default_nettype none

module result_bus_top (
	input logic clk,
	input logic reset,
	// integer sources
	input logic ftoi_req,
	input result_bus_pkg::tag_t ftoi_tag,
	input result_bus_pkg::data_t ftoi_data,
	output logic ftoi_ready,
	input logic gpr_lw_req,
	input result_bus_pkg::tag_t gpr_lw_tag,
	input result_bus_pkg::data_t gpr_lw_data,
	output logic gpr_lw_ready,
	input logic add_sub_req,
	input result_bus_pkg::tag_t add_sub_tag,
	input result_bus_pkg::data_t add_sub_data,
	output logic add_sub_ready,
	input logic mov_req,
	input result_bus_pkg::tag_t mov_tag,
	input result_bus_pkg::data_t mov_data,
	output logic mov_ready,
	input logic gpr_in_req,
	input result_bus_pkg::tag_t gpr_in_tag,
	input result_bus_pkg::data_t gpr_in_data,
	output logic gpr_in_ready,
	output logic gpr_cdb_valid,
	output result_bus_pkg::tag_t gpr_cdb_tag,
	output result_bus_pkg::data_t gpr_cdb_data,
	// floating-point sources
	input logic fdiv_fsqrt_req,
	input result_bus_pkg::tag_t fdiv_fsqrt_tag,
	input result_bus_pkg::data_t fdiv_fsqrt_data,
	output logic fdiv_fsqrt_ready,
	input logic fadd_fsub_req,
	input result_bus_pkg::tag_t fadd_fsub_tag,
	input result_bus_pkg::data_t fadd_fsub_data,
	output logic fadd_fsub_ready,
	input logic fmul_req,
	input result_bus_pkg::tag_t fmul_tag,
	input result_bus_pkg::data_t fmul_data,
	output logic fmul_ready,
	input logic itof_req,
	input result_bus_pkg::tag_t itof_tag,
	input result_bus_pkg::data_t itof_data,
	output logic itof_ready,
	input logic fpr_lw_req,
	input result_bus_pkg::tag_t fpr_lw_tag,
	input result_bus_pkg::data_t fpr_lw_data,
	output logic fpr_lw_ready,
	input logic fmov_req,
	input result_bus_pkg::tag_t fmov_tag,
	input result_bus_pkg::data_t fmov_data,
	output logic fmov_ready,
	input logic fpr_in_req,
	input result_bus_pkg::tag_t fpr_in_tag,
	input result_bus_pkg::data_t fpr_in_data,
	output logic fpr_in_ready,
	output logic fpr_cdb_valid,
	output result_bus_pkg::tag_t fpr_cdb_tag,
	output result_bus_pkg::data_t fpr_cdb_data
);

	// the two buses are independent
	gpr_bus_arbiter gpr_bus_i (.*);

	fpr_bus_arbiter fpr_bus_i (.*);

endmodule

`default_nettype wire

//--- hw/result_pipe.sv
`default_nettype none

module result_pipe #(
	parameter int STAGES = 1
) (
	input logic clk,
	input result_bus_pkg::tag_t in_tag,
	input result_bus_pkg::data_t in_data,
	output result_bus_pkg::tag_t out_tag,
	output result_bus_pkg::data_t out_data
);
	import result_bus_pkg::*;

	tag_t tag_q [STAGES];
	data_t data_q [STAGES];

	// occupancy lives in the slot ring
	always_ff @(posedge clk) begin
		tag_q[0] <= in_tag;
		data_q[0] <= in_data;
		for (int i = 1; i < STAGES; i++) begin
			tag_q[i] <= tag_q[i-1];
			data_q[i] <= data_q[i-1];
		end
	end

	assign out_tag = tag_q[STAGES-1];
	assign out_data = data_q[STAGES-1];

endmodule

`default_nettype wire

//--- hw/slot_reservation.sv
`default_nettype none

module slot_reservation #(
	parameter int DEPTH = 3
) (
	input logic clk,
	input logic reset,
	input logic [DEPTH-1:0] insert,
	input logic [2:0] insert_unit [DEPTH],
	output logic [DEPTH-1:0] occupied,
	output logic [2:0] head_unit
);
	logic [DEPTH-1:0] valid_q;
	logic [2:0] unit_q [DEPTH];

	// reservations step one slot toward the bus per clock
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
		end else begin
			valid_q[DEPTH-1] <= insert[DEPTH-1];
			for (int i = 0; i < DEPTH-1; i++) begin
				valid_q[i] <= valid_q[i+1] || insert[i];
			end
		end
	end

	// source id follows its reservation
	// an insert only lands where the slot above is empty
	always_ff @(posedge clk) begin
		unit_q[DEPTH-1] <= insert_unit[DEPTH-1];
		for (int i = 0; i < DEPTH-1; i++) begin
			unit_q[i] <= valid_q[i+1] ? unit_q[i+1] : insert_unit[i];
		end
	end

	assign occupied = valid_q;

	// slot 0 is the bus this cycle
	assign head_unit = unit_q[0];

endmodule

`default_nettype wire

//--- result_bus.f
hw/result_bus_pkg.sv
hw/slot_reservation.sv
hw/result_pipe.sv
hw/gpr_bus_arbiter.sv
hw/fpr_bus_arbiter.sv
hw/result_bus_top.sv
test/bus_scoreboard.sv
test/tb_result_bus.sv

//--- test/bus_scoreboard.sv
`default_nettype none

module bus_scoreboard #(
	parameter bit FPR = 1'b0,
	parameter int SOURCES = 5,
	parameter int SLOTS = 3
) (
	input logic clk,
	input logic reset,
	input logic [SOURCES-1:0] req,
	input result_bus_pkg::tag_t tag [SOURCES],
	input result_bus_pkg::data_t data [SOURCES],
	output logic [SOURCES-1:0] ready,
	output logic cdb_valid,
	output result_bus_pkg::tag_t cdb_tag,
	output result_bus_pkg::data_t cdb_data
);
	timeunit 1ns;
	timeprecision 1ps;

	import result_bus_pkg::*;

	logic pend_valid [SLOTS];
	tag_t pend_tag [SLOTS];
	data_t pend_data [SLOTS];

	// in-source sits at the last index with latency zero
	function automatic int latency(input int s);
		int gpr_lat [5];
		int fpr_lat [7];
		gpr_lat = '{LAT_FTOI, LAT_GPR_LW, LAT_ADD_SUB, LAT_MOV, 0};
		fpr_lat = '{LAT_FDIV_FSQRT, LAT_FADD_FSUB, LAT_FMUL, LAT_ITOF,
			LAT_FPR_LW, LAT_FMOV, 0};
		return FPR ? fpr_lat[s] : gpr_lat[s];
	endfunction

	////////////////////
	// predicted readies
	////////////////////

	always_comb begin
		for (int s = 0; s < SOURCES; s++) begin
			if (latency(s) == 0) begin
				ready[s] = !pend_valid[0];
			end else if (latency(s) == SLOTS) begin
				ready[s] = 1'b1;
			end else begin
				ready[s] = !pend_valid[latency(s)];
			end
			// lower index wins at equal latency
			for (int h = 0; h < s; h++) begin
				if (latency(h) == latency(s) && req[h]) begin
					ready[s] = 1'b0;
				end
			end
		end
	end

	assign cdb_valid = pend_valid[0] || (req[SOURCES-1] && ready[SOURCES-1]);
	assign cdb_tag = pend_valid[0] ? pend_tag[0] : tag[SOURCES-1];
	assign cdb_data = pend_valid[0] ? pend_data[0] : data[SOURCES-1];

	////////////////////
	// pending results
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < SLOTS; i++) begin
				pend_valid[i] <= 1'b0;
			end
		end else begin
			for (int i = 0; i < SLOTS-1; i++) begin
				pend_valid[i] <= pend_valid[i+1];
				pend_tag[i] <= pend_tag[i+1];
				pend_data[i] <= pend_data[i+1];
			end
			pend_valid[SLOTS-1] <= 1'b0;
			// accepted result lands L-1 slots above the bus
			for (int s = 0; s < SOURCES; s++) begin
				if (req[s] && ready[s] && latency(s) > 0) begin
					pend_valid[latency(s)-1] <= 1'b1;
					pend_tag[latency(s)-1] <= tag[s];
					pend_data[latency(s)-1] <= data[s];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- test/tb_result_bus.sv
`default_nettype none

module tb_result_bus;
	timeunit 1ns;
	timeprecision 1ps;

	import result_bus_pkg::*;

	localparam int GPR_SOURCES = 5;
	localparam int FPR_SOURCES = 7;
	localparam int RANDOM_CYCLES = 2000;
	// directed phases, mid-run reset and drain fit well inside 200 cycles
	localparam int TIMEOUT_CYCLES = RANDOM_CYCLES + 200;

	logic clk;
	logic reset;
	int cycles = 0;

	// index order follows source priority with the in-source last
	logic [GPR_SOURCES-1:0] gpr_req;
	tag_t gpr_tag [GPR_SOURCES];
	data_t gpr_data [GPR_SOURCES];
	wire [GPR_SOURCES-1:0] gpr_ready;
	logic gpr_cdb_valid;
	tag_t gpr_cdb_tag;
	data_t gpr_cdb_data;

	logic [FPR_SOURCES-1:0] fpr_req;
	tag_t fpr_tag [FPR_SOURCES];
	data_t fpr_data [FPR_SOURCES];
	wire [FPR_SOURCES-1:0] fpr_ready;
	logic fpr_cdb_valid;
	tag_t fpr_cdb_tag;
	data_t fpr_cdb_data;

	logic [GPR_SOURCES-1:0] gpr_ready_exp;
	logic gpr_valid_exp;
	tag_t gpr_tag_exp;
	data_t gpr_data_exp;
	logic [FPR_SOURCES-1:0] fpr_ready_exp;
	logic fpr_valid_exp;
	tag_t fpr_tag_exp;
	data_t fpr_data_exp;

	int gpr_accepted;
	int gpr_delivered;
	int fpr_accepted;
	int fpr_delivered;

	result_bus_top dut_i (
		.clk(clk),
		.reset(reset),
		.ftoi_req(gpr_req[0]),
		.ftoi_tag(gpr_tag[0]),
		.ftoi_data(gpr_data[0]),
		.ftoi_ready(gpr_ready[0]),
		.gpr_lw_req(gpr_req[1]),
		.gpr_lw_tag(gpr_tag[1]),
		.gpr_lw_data(gpr_data[1]),
		.gpr_lw_ready(gpr_ready[1]),
		.add_sub_req(gpr_req[2]),
		.add_sub_tag(gpr_tag[2]),
		.add_sub_data(gpr_data[2]),
		.add_sub_ready(gpr_ready[2]),
		.mov_req(gpr_req[3]),
		.mov_tag(gpr_tag[3]),
		.mov_data(gpr_data[3]),
		.mov_ready(gpr_ready[3]),
		.gpr_in_req(gpr_req[4]),
		.gpr_in_tag(gpr_tag[4]),
		.gpr_in_data(gpr_data[4]),
		.gpr_in_ready(gpr_ready[4]),
		.gpr_cdb_valid(gpr_cdb_valid),
		.gpr_cdb_tag(gpr_cdb_tag),
		.gpr_cdb_data(gpr_cdb_data),
		.fdiv_fsqrt_req(fpr_req[0]),
		.fdiv_fsqrt_tag(fpr_tag[0]),
		.fdiv_fsqrt_data(fpr_data[0]),
		.fdiv_fsqrt_ready(fpr_ready[0]),
		.fadd_fsub_req(fpr_req[1]),
		.fadd_fsub_tag(fpr_tag[1]),
		.fadd_fsub_data(fpr_data[1]),
		.fadd_fsub_ready(fpr_ready[1]),
		.fmul_req(fpr_req[2]),
		.fmul_tag(fpr_tag[2]),
		.fmul_data(fpr_data[2]),
		.fmul_ready(fpr_ready[2]),
		.itof_req(fpr_req[3]),
		.itof_tag(fpr_tag[3]),
		.itof_data(fpr_data[3]),
		.itof_ready(fpr_ready[3]),
		.fpr_lw_req(fpr_req[4]),
		.fpr_lw_tag(fpr_tag[4]),
		.fpr_lw_data(fpr_data[4]),
		.fpr_lw_ready(fpr_ready[4]),
		.fmov_req(fpr_req[5]),
		.fmov_tag(fpr_tag[5]),
		.fmov_data(fpr_data[5]),
		.fmov_ready(fpr_ready[5]),
		.fpr_in_req(fpr_req[6]),
		.fpr_in_tag(fpr_tag[6]),
		.fpr_in_data(fpr_data[6]),
		.fpr_in_ready(fpr_ready[6]),
		.fpr_cdb_valid(fpr_cdb_valid),
		.fpr_cdb_tag(fpr_cdb_tag),
		.fpr_cdb_data(fpr_cdb_data)
	);

	bus_scoreboard #(.FPR(1'b0), .SOURCES(GPR_SOURCES), .SLOTS(GPR_SLOTS)) gpr_model_i (
		.clk(clk),
		.reset(reset),
		.req(gpr_req),
		.tag(gpr_tag),
		.data(gpr_data),
		.ready(gpr_ready_exp),
		.cdb_valid(gpr_valid_exp),
		.cdb_tag(gpr_tag_exp),
		.cdb_data(gpr_data_exp)
	);

	bus_scoreboard #(.FPR(1'b1), .SOURCES(FPR_SOURCES), .SLOTS(FPR_SLOTS)) fpr_model_i (
		.clk(clk),
		.reset(reset),
		.req(fpr_req),
		.tag(fpr_tag),
		.data(fpr_data),
		.ready(fpr_ready_exp),
		.cdb_valid(fpr_valid_exp),
		.cdb_tag(fpr_tag_exp),
		.cdb_data(fpr_data_exp)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Simulation FAILED");
			$fatal(1, "timeout");
		end
	end

	////////////////////
	// helpers
	////////////////////

	function automatic string source_name(input bit fpr, input int s);
		string gpr_names [GPR_SOURCES];
		string fpr_names [FPR_SOURCES];
		gpr_names = '{"ftoi", "gpr_lw", "add_sub", "mov", "gpr_in"};
		fpr_names = '{"fdiv_fsqrt", "fadd_fsub", "fmul", "itof", "fpr_lw", "fmov", "fpr_in"};
		return fpr ? fpr_names[s] : gpr_names[s];
	endfunction

	function automatic int source_latency(input bit fpr, input int s);
		int gpr_lat [GPR_SOURCES];
		int fpr_lat [FPR_SOURCES];
		gpr_lat = '{LAT_FTOI, LAT_GPR_LW, LAT_ADD_SUB, LAT_MOV, 0};
		fpr_lat = '{LAT_FDIV_FSQRT, LAT_FADD_FSUB, LAT_FMUL, LAT_ITOF,
			LAT_FPR_LW, LAT_FMOV, 0};
		return fpr ? fpr_lat[s] : gpr_lat[s];
	endfunction

	task automatic check_value(
		input string name,
		input logic [31:0] actual,
		input logic [31:0] expected
	);
		if (actual !== expected) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("Simulation FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic drive_source(
		input bit fpr,
		input int s,
		input logic req,
		input tag_t t,
		input data_t d
	);
		if (fpr) begin
			fpr_req[s] <= req;
			fpr_tag[s] <= t;
			fpr_data[s] <= d;
		end else begin
			gpr_req[s] <= req;
			gpr_tag[s] <= t;
			gpr_data[s] <= d;
		end
	endtask

	task automatic idle_inputs();
		gpr_req <= '0;
		fpr_req <= '0;
	endtask

	// every cycle compares the DUT with both models
	always @(negedge clk) begin
		if (reset) begin
			gpr_accepted = 0;
			gpr_delivered = 0;
			fpr_accepted = 0;
			fpr_delivered = 0;
		end else begin
			for (int s = 0; s < GPR_SOURCES; s++) begin
				check_value({source_name(1'b0, s), "_ready"}, gpr_ready[s], gpr_ready_exp[s]);
			end
			for (int s = 0; s < FPR_SOURCES; s++) begin
				check_value({source_name(1'b1, s), "_ready"}, fpr_ready[s], fpr_ready_exp[s]);
			end
			check_value("gpr_cdb_valid", gpr_cdb_valid, gpr_valid_exp);
			check_value("fpr_cdb_valid", fpr_cdb_valid, fpr_valid_exp);
			if (gpr_valid_exp) begin
				check_value("gpr_cdb_tag", gpr_cdb_tag, gpr_tag_exp);
				check_value("gpr_cdb_data", gpr_cdb_data, gpr_data_exp);
			end
			if (fpr_valid_exp) begin
				check_value("fpr_cdb_tag", fpr_cdb_tag, fpr_tag_exp);
				check_value("fpr_cdb_data", fpr_cdb_data, fpr_data_exp);
			end
			gpr_accepted += $countones(gpr_req & gpr_ready);
			fpr_accepted += $countones(fpr_req & fpr_ready);
			gpr_delivered += int'(gpr_cdb_valid);
			fpr_delivered += int'(fpr_cdb_valid);
		end
	end

	////////////////////
	// directed phases
	////////////////////

	task automatic check_idle(input int count);
		for (int c = 0; c < count; c++) begin
			@(negedge clk);
			for (int s = 0; s < GPR_SOURCES; s++) begin
				check_value({source_name(1'b0, s), "_ready"}, gpr_ready[s], 1);
			end
			for (int s = 0; s < FPR_SOURCES; s++) begin
				check_value({source_name(1'b1, s), "_ready"}, fpr_ready[s], 1);
			end
			check_value("gpr_cdb_valid", gpr_cdb_valid, 0);
			check_value("fpr_cdb_valid", fpr_cdb_valid, 0);
		end
	endtask

	task automatic lone_request(input bit fpr, input int s);
		tag_t t;
		data_t d;
		int lat;
		int waited;
		t = tag_t'($urandom);
		d = $urandom;
		lat = source_latency(fpr, s);
		@(posedge clk);
		drive_source(fpr, s, 1'b1, t, d);
		@(negedge clk);
		check_value({source_name(fpr, s), "_ready"}, fpr ? fpr_ready[s] : gpr_ready[s], 1);
		waited = 0;
		if (lat > 0) begin
			// this edge accepts the request
			@(posedge clk);
			drive_source(fpr, s, 1'b0, ~t, ~d);
			waited = 1;
			@(negedge clk);
			while (!(fpr ? fpr_cdb_valid : gpr_cdb_valid) && waited <= lat) begin
				@(negedge clk);
				waited++;
			end
		end
		check_value({source_name(fpr, s), " latency"}, waited, lat);
		check_value(fpr ? "fpr_cdb_valid" : "gpr_cdb_valid",
			fpr ? fpr_cdb_valid : gpr_cdb_valid, 1);
		check_value(fpr ? "fpr_cdb_tag" : "gpr_cdb_tag", fpr ? fpr_cdb_tag : gpr_cdb_tag, t);
		check_value(fpr ? "fpr_cdb_data" : "gpr_cdb_data", fpr ? fpr_cdb_data : gpr_cdb_data, d);
		if (lat == 0) begin
			@(posedge clk);
			idle_inputs();
		end
	endtask

	// all one-cycle sources at once
	task automatic priority_check();
		tag_t lw_tag;
		data_t lw_data;
		tag_t flw_tag;
		data_t flw_data;
		lw_tag = tag_t'($urandom);
		lw_data = $urandom;
		flw_tag = tag_t'($urandom);
		flw_data = $urandom;
		@(posedge clk);
		drive_source(1'b0, 1, 1'b1, lw_tag, lw_data);
		drive_source(1'b0, 2, 1'b1, tag_t'($urandom), $urandom);
		drive_source(1'b0, 3, 1'b1, tag_t'($urandom), $urandom);
		drive_source(1'b1, 4, 1'b1, flw_tag, flw_data);
		drive_source(1'b1, 5, 1'b1, tag_t'($urandom), $urandom);
		@(negedge clk);
		check_value("gpr_lw_ready", gpr_ready[1], 1);
		check_value("add_sub_ready", gpr_ready[2], 0);
		check_value("mov_ready", gpr_ready[3], 0);
		check_value("fpr_lw_ready", fpr_ready[4], 1);
		check_value("fmov_ready", fpr_ready[5], 0);
		@(posedge clk);
		idle_inputs();
		drive_source(1'b0, 1, 1'b0, ~lw_tag, ~lw_data);
		drive_source(1'b1, 4, 1'b0, ~flw_tag, ~flw_data);
		@(negedge clk);
		check_value("gpr_cdb_tag", gpr_cdb_tag, lw_tag);
		check_value("gpr_cdb_data", gpr_cdb_data, lw_data);
		check_value("fpr_cdb_tag", fpr_cdb_tag, flw_tag);
		check_value("fpr_cdb_data", fpr_cdb_data, flw_data);
	endtask

	// one fdiv reservation walks down the ring past every shorter source
	task automatic long_op_blocking();
		tag_t t;
		data_t d;
		int slot;
		t = tag_t'($urandom);
		d = $urandom;
		@(posedge clk);
		drive_source(1'b1, 0, 1'b1, t, d);
		@(negedge clk);
		check_value("fdiv_fsqrt_ready", fpr_ready[0], 1);
		@(posedge clk);
		idle_inputs();
		drive_source(1'b1, 0, 1'b0, ~t, ~d);
		for (int j = 0; j < LAT_FDIV_FSQRT; j++) begin
			@(negedge clk);
			slot = LAT_FDIV_FSQRT - 1 - j;
			for (int s = 1; s < FPR_SOURCES; s++) begin
				check_value({source_name(1'b1, s), "_ready"}, fpr_ready[s],
					32'(slot != source_latency(1'b1, s)));
			end
			if (slot == 0) begin
				check_value("fpr_cdb_tag", fpr_cdb_tag, t);
				check_value("fpr_cdb_data", fpr_cdb_data, d);
			end
		end
	endtask

	task automatic random_cycles(input int count);
		int density;
		density = 30;
		for (int c = 0; c < count; c++) begin
			// load level changes every hundred cycles
			if (c % 100 == 0) begin
				density = $urandom_range(10, 70);
			end
			@(posedge clk);
			for (int s = 0; s < GPR_SOURCES; s++) begin
				drive_source(1'b0, s, $urandom_range(0, 99) < density,
					tag_t'($urandom), $urandom);
			end
			for (int s = 0; s < FPR_SOURCES; s++) begin
				drive_source(1'b1, s, $urandom_range(0, 99) < density,
					tag_t'($urandom), $urandom);
			end
		end
	endtask

	task automatic mid_run_reset();
		@(posedge clk);
		idle_inputs();
		reset <= 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		// pending fdiv results would have landed in this window
		check_idle(LAT_FDIV_FSQRT);
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		void'($urandom(33));
		reset = 1'b1;
		gpr_req = '0;
		fpr_req = '0;
		for (int s = 0; s < GPR_SOURCES; s++) begin
			gpr_tag[s] = '0;
			gpr_data[s] = '0;
		end
		for (int s = 0; s < FPR_SOURCES; s++) begin
			fpr_tag[s] = '0;
			fpr_data[s] = '0;
		end
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		check_idle(1);
		for (int s = 0; s < GPR_SOURCES; s++) begin
			lone_request(1'b0, s);
		end
		for (int s = 0; s < FPR_SOURCES; s++) begin
			lone_request(1'b1, s);
		end
		priority_check();
		long_op_blocking();
		random_cycles(RANDOM_CYCLES / 2);
		mid_run_reset();
		random_cycles(RANDOM_CYCLES / 2);
		@(posedge clk);
		idle_inputs();
		repeat (LAT_FDIV_FSQRT + 4) @(posedge clk);
		if (gpr_accepted == gpr_delivered && fpr_accepted == fpr_delivered) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("accepted and delivered result counts differ: gpr %0d/%0d fpr %0d/%0d",
				gpr_accepted, gpr_delivered, fpr_accepted, fpr_delivered);
			$display("Simulation FAILED");
			$fatal(1, "result count mismatch");
		end
	end

endmodule

`default_nettype wire
